// File: hw/vga_frame_pkg.sv
// frame buffer scanout package with raster geometry, queue sizing and shared vector types
package vga_frame_pkg;

   // ---------------------------------------------------------------------
   // raster geometry, 1024x768 at 60 Hz
   // ---------------------------------------------------------------------
   localparam int H_ACTIVE     = 1024;
   localparam int H_SYNC_START = 1048;
   localparam int H_SYNC_END   = 1184;
   localparam int H_TOTAL      = 1344;

   localparam int V_ACTIVE     = 768;
   localparam int V_SYNC_START = 777;
   localparam int V_SYNC_END   = 783;
   localparam int V_TOTAL      = 806;

   // ---------------------------------------------------------------------
   // scanout pipeline
   // ---------------------------------------------------------------------
   // read lookahead in pixels
   localparam int FORECAST    = 8;
   // cycles from read issue to data on the ram bus
   localparam int RAM_LATENCY = 2;
   // how far the unpacked pixel runs ahead of the raster
   // two cycles go to the latch and display registers
   localparam int PIX_LEAD    = FORECAST - RAM_LATENCY - 2;

   // write queue depth, same as the writer's starting credits
   localparam int WR_CREDITS  = 4;
   localparam int QPTR_W      = $clog2(WR_CREDITS);
   localparam int QCNT_W      = $clog2(WR_CREDITS + 1);

   // ---------------------------------------------------------------------
   // vector types
   // ---------------------------------------------------------------------
   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;
   // line in [18:9], column/2 in [8:0]
   typedef logic [18:0] vram_addr_t;
   // even pixel in [35:18], odd pixel in [17:0]
   typedef logic [35:0] vram_word_t;
   // red [17:12], green [11:6], blue [5:0]
   typedef logic [17:0] pixel_t;
   typedef logic [7:0]  colour_t;

endpackage

// File: hw/vga_frame_ifs.sv
// raster timing and frame write request interfaces for the scanout pipeline
`timescale 1ns/1ps

// ---------------------------------------------------------------------
// raster position plus sync and blank
// ---------------------------------------------------------------------
interface raster_if import vga_frame_pkg::*; ();
   hcount_t hcount;
   vcount_t vcount;
   // both syncs active low
   logic    hsync;
   logic    vsync;
   // high outside the visible area
   logic    blank;

   modport source (
      output hcount, vcount, hsync, vsync, blank
   );

   modport sink (
      input hcount, vcount, hsync, vsync, blank
   );
endinterface

// ---------------------------------------------------------------------
// queue head towards the ram arbiter
// ---------------------------------------------------------------------
interface write_req_if import vga_frame_pkg::*; ();
   logic       valid;
   vram_addr_t addr;
   vram_word_t data;
   // only with valid high, entry leaves at that edge
   logic       pop;

   modport queue (
      output valid, addr, data,
      input  pop
   );

   modport arbiter (
      input  valid, addr, data,
      output pop
   );
endinterface

// File: hw/video_timing_gen.sv
// raster timing generator with column and line counters and registered sync and blank
`timescale 1ns/1ps

module video_timing_gen import vga_frame_pkg::*; (
   input logic     clk,
   input logic     reset,
   raster_if.source raster
);

   hcount_t h_cnt;
   vcount_t v_cnt;
   hcount_t h_nxt;
   vcount_t v_nxt;
   logic    line_end;
   logic    hsync_r;
   logic    vsync_r;
   logic    blank_r;

   // ---------------------------------------------------------------------
   // next raster position
   // ---------------------------------------------------------------------
   assign line_end = (h_cnt == hcount_t'(H_TOTAL - 1));

   always_comb begin
      if (line_end) begin
         h_nxt = '0;
         // line wraps at the bottom of the frame
         if (v_cnt == vcount_t'(V_TOTAL - 1)) begin
            v_nxt = '0;
         end else begin
            v_nxt = v_cnt + 1'b1;
         end
      end else begin
         h_nxt = h_cnt + 1'b1;
         v_nxt = v_cnt;
      end
   end

   // ---------------------------------------------------------------------
   // counters and sync registers
   // ---------------------------------------------------------------------
   // sync and blank are decoded from the next position,
   // so once registered they line up with the counters
   always_ff @(posedge clk) begin
      if (reset) begin
         h_cnt   <= '0;
         v_cnt   <= '0;
         hsync_r <= 1'b1;
         vsync_r <= 1'b1;
         // position 0,0 is visible
         blank_r <= 1'b0;
      end else begin
         h_cnt   <= h_nxt;
         v_cnt   <= v_nxt;
         hsync_r <= !((h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_END));
         vsync_r <= !((v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_END));
         blank_r <= (h_nxt >= H_ACTIVE) || (v_nxt >= V_ACTIVE);
      end
   end

   assign raster.hcount = h_cnt;
   assign raster.vcount = v_cnt;
   assign raster.hsync  = hsync_r;
   assign raster.vsync  = vsync_r;
   assign raster.blank  = blank_r;

endmodule

// File: hw/frame_write_queue.sv
// credited write queue that holds frame buffer writes until the arbiter takes them
`timescale 1ns/1ps

module frame_write_queue import vga_frame_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        wr_valid,
   input  vram_addr_t  wr_addr,
   input  vram_word_t  wr_data,
   output logic        wr_credit,
   write_req_if.queue  req
);

   // entry storage, address and data side by side
   vram_addr_t        addr_mem [WR_CREDITS];
   vram_word_t        data_mem [WR_CREDITS];

   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;

   // ---------------------------------------------------------------------
   // storage
   // ---------------------------------------------------------------------
   // the writer only sends with a credit in hand
   // so a push never lands on a full queue
   always_ff @(posedge clk) begin
      if (wr_valid) begin
         addr_mem[wr_ptr] <= wr_addr;
         data_mem[wr_ptr] <= wr_data;
      end
   end

   // ---------------------------------------------------------------------
   // pointers, occupancy and credit return
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         wr_credit <= 1'b0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= (wr_ptr == QPTR_W'(WR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (req.pop) begin
            rd_ptr <= (rd_ptr == QPTR_W'(WR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // push and pop together leave the count alone
         case ({wr_valid, req.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // one credit back per committed word
         wr_credit <= req.pop;
      end
   end

   // head of queue, visible the cycle after the push
   assign req.valid = (count != '0);
   assign req.addr  = addr_mem[rd_ptr];
   assign req.data  = data_mem[rd_ptr];

endmodule

// File: hw/vram_arbiter.sv
// ram port arbiter with forecast scanout reads on even columns and queued writes on odd ones
`timescale 1ns/1ps

module vram_arbiter import vga_frame_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   raster_if.sink       raster,
   write_req_if.arbiter req,
   output vram_addr_t   ram_addr,
   output logic         ram_we,
   output vram_word_t   ram_wdata
);

   hcount_t    fc_col_raw;
   hcount_t    fc_col;
   vcount_t    fc_line;
   vram_addr_t scan_addr;
   logic       write_slot;

   // ---------------------------------------------------------------------
   // scanout forecast
   // ---------------------------------------------------------------------
   // the address register is loaded one cycle early, so it is
   // worked out for the position after the next one plus FORECAST
   assign fc_col_raw = raster.hcount + hcount_t'(FORECAST + 1);

   always_comb begin
      if (fc_col_raw >= H_TOTAL) begin
         // runs off the end of the line, into the next one
         fc_col = fc_col_raw - hcount_t'(H_TOTAL);
         if (raster.vcount == vcount_t'(V_TOTAL - 1)) begin
            fc_line = '0;
         end else begin
            fc_line = raster.vcount + 1'b1;
         end
      end else begin
         fc_col  = fc_col_raw;
         fc_line = raster.vcount;
      end
   end

   // word address is line and column/2
   // columns in the blanking interval alias harmlessly
   always_ff @(posedge clk) begin
      if (reset) begin
         // counters restart at 0,0 so the first read is for column FORECAST
         scan_addr <= vram_addr_t'(FORECAST / 2);
      end else begin
         scan_addr <= {fc_line, fc_col[9:1]};
      end
   end

   // ---------------------------------------------------------------------
   // slot selection
   // ---------------------------------------------------------------------
   // odd columns belong to the write queue, even columns to scanout
   assign write_slot = raster.hcount[0];

   assign ram_we    = write_slot && req.valid;
   assign req.pop   = ram_we;
   // idle odd slots still drive the scan address
   assign ram_addr  = ram_we ? req.addr : scan_addr;
   assign ram_wdata = req.data;

endmodule

// File: hw/pixel_unpack.sv
// pixel unpacker that splits ram words into pixels and aligns them with sync and blank
`timescale 1ns/1ps

module pixel_unpack import vga_frame_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   raster_if.sink     raster,
   input  vram_word_t ram_rdata,
   output colour_t    vga_red,
   output colour_t    vga_green,
   output colour_t    vga_blue,
   output logic       vga_hsync,
   output logic       vga_vsync,
   output logic       vga_blank_b
);

   vram_word_t word_latched;
   vram_word_t word_disp;
   pixel_t     pix_sel;
   // lookahead delay so the pixel meets its own raster position
   pixel_t     pix_pipe [PIX_LEAD];

   // ---------------------------------------------------------------------
   // word capture
   // ---------------------------------------------------------------------
   // reads go out on even columns and come back two cycles later,
   // again on an even column
   always_ff @(posedge clk) begin
      if (!raster.hcount[0]) begin
         word_latched <= ram_rdata;
      end
   end

   // hand over on the odd column so the display word
   // stays put for an even/odd pair
   always_ff @(posedge clk) begin
      if (raster.hcount[0]) begin
         word_disp <= word_latched;
      end
   end

   // even column takes the upper half
   assign pix_sel = raster.hcount[0] ? word_disp[17:0] : word_disp[35:18];

   // ---------------------------------------------------------------------
   // alignment
   // ---------------------------------------------------------------------
   // pix_sel is PIX_LEAD positions ahead of the raster
   always_ff @(posedge clk) begin
      pix_pipe[0] <= pix_sel;
      for (int i = 1; i < PIX_LEAD; i++) begin
         pix_pipe[i] <= pix_pipe[i-1];
      end
   end

   // ---------------------------------------------------------------------
   // output registers
   // ---------------------------------------------------------------------
   // 6-bit fields go out on the top of each 8-bit channel
   always_ff @(posedge clk) begin
      vga_red   <= {pix_pipe[PIX_LEAD-1][17:12], 2'b00};
      vga_green <= {pix_pipe[PIX_LEAD-1][11:6], 2'b00};
      vga_blue  <= {pix_pipe[PIX_LEAD-1][5:0], 2'b00};
   end

   // sync and blank take one register, same as the colour channels
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
         vga_blank_b <= 1'b0;
      end else begin
         vga_hsync   <= raster.hsync;
         vga_vsync   <= raster.vsync;
         vga_blank_b <= !raster.blank;
      end
   end

endmodule

// File: hw/vga_frame_top.sv
// frame buffer scanout engine top with timing, write queue, ram arbiter and pixel output
`timescale 1ns/1ps

module vga_frame_top import vga_frame_pkg::*; (
   input  logic       clk,
   input  logic       reset,

   // credited frame buffer write stream
   input  logic       wr_valid,
   input  vram_addr_t wr_addr,
   input  vram_word_t wr_data,
   output logic       wr_credit,

   // synchronous ram, two cycles of read latency
   output vram_addr_t ram_addr,
   output logic       ram_we,
   output vram_word_t ram_wdata,
   input  vram_word_t ram_rdata,

   // vga output
   output colour_t    vga_red,
   output colour_t    vga_green,
   output colour_t    vga_blue,
   output logic       vga_hsync,
   output logic       vga_vsync,
   output logic       vga_blank_b
);

   raster_if    raster ();
   write_req_if wreq ();

   // ---------------------------------------------------------------------
   // raster timing
   // ---------------------------------------------------------------------
   video_timing_gen i_timing (
      .clk    (clk),
      .reset  (reset),
      .raster (raster.source)
   );

   // ---------------------------------------------------------------------
   // write path
   // ---------------------------------------------------------------------
   frame_write_queue i_queue (
      .clk       (clk),
      .reset     (reset),
      .wr_valid  (wr_valid),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_credit (wr_credit),
      .req       (wreq.queue)
   );

   // one ram port shared by scanout and writes
   vram_arbiter i_arbiter (
      .clk       (clk),
      .reset     (reset),
      .raster    (raster.sink),
      .req       (wreq.arbiter),
      .ram_addr  (ram_addr),
      .ram_we    (ram_we),
      .ram_wdata (ram_wdata)
   );

   // ---------------------------------------------------------------------
   // scanout path
   // ---------------------------------------------------------------------
   pixel_unpack i_unpack (
      .clk         (clk),
      .reset       (reset),
      .raster      (raster.sink),
      .ram_rdata   (ram_rdata),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_b (vga_blank_b)
   );

endmodule

// File: verification/vga_frame_tb.sv
// testbench for the frame buffer scanout engine with ram model, credited writer and raster checks
`timescale 1ns/1ps

module vga_frame_tb import vga_frame_pkg::*; ();

   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   // reset and writes fit in the first frame and the second one is checked
   localparam int MAX_CYCLES   = 3 * H_TOTAL * V_TOTAL + 1000;

   logic       clk;
   logic       reset;
   logic       wr_valid;
   vram_addr_t wr_addr;
   vram_word_t wr_data;
   logic       wr_credit;
   vram_addr_t ram_addr;
   logic       ram_we;
   vram_word_t ram_wdata;
   vram_word_t ram_rdata = '0;
   colour_t    vga_red;
   colour_t    vga_green;
   colour_t    vga_blue;
   logic       vga_hsync;
   logic       vga_vsync;
   logic       vga_blank_b;

   // ram model state
   vram_word_t mem [0:(1 << 19) - 1];
   vram_addr_t addr_s;
   logic       we_s;
   vram_word_t wdata_s;
   vram_word_t rd_stage = '0;

   // records from the data file
   vram_addr_t wr_addr_q [$];
   vram_word_t wr_data_q [$];
   // expected pixel keyed by line * H_TOTAL + column
   pixel_t     probe_map [int];

   int credits;
   int words_sent;
   int ram_writes = 0;
   int cycle_count = 0;

   vga_frame_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // ---------------------------------------------------------------------
   // synchronous ram with the port sampled at the edge and the bus driven 2 ns later
   // ---------------------------------------------------------------------
   always @(posedge clk) begin
      addr_s  = ram_addr;
      we_s    = ram_we;
      wdata_s = ram_wdata;
      #2;
      if (we_s) begin
         mem[addr_s] = wdata_s;
         ram_writes++;
      end
      // two stages so that a read at cycle t shows up at t+2
      ram_rdata = rd_stage;
      rd_stage  = mem[addr_s];
   end

   // credit returns counted on the falling edge where wr_credit is stable
   always @(negedge clk) begin
      if (wr_credit === 1'b1) begin
         credits++;
         check_bit("credit count within limit", 1'b1, credits <= WR_CREDITS);
      end
   end

   // ---------------------------------------------------------------------
   // compare tasks
   // ---------------------------------------------------------------------
   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input hcount_t exp, input hcount_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_reset_outputs(input string when);
      check_bit({"wr_credit ", when}, 1'b0, wr_credit);
      check_bit({"ram_we ", when}, 1'b0, ram_we);
      check_bit({"vga_blank_b ", when}, 1'b0, vga_blank_b);
      check_bit({"vga_hsync ", when}, 1'b1, vga_hsync);
      check_bit({"vga_vsync ", when}, 1'b1, vga_vsync);
   endtask

   // ---------------------------------------------------------------------
   // stimulus
   // ---------------------------------------------------------------------
   task automatic load_testdata();
      int         fd;
      string      text;
      vram_addr_t a;
      vram_word_t d;
      int         col;
      int         ln;
      pixel_t     p;
      fd = $fopen("verification/vga_frame_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open verification/vga_frame_testdata.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         text = "";
         void'($fgets(text, fd));
         // anything but W and P lines is a comment
         if (text.len() > 1 && text[0] == "W") begin
            void'($sscanf(text.substr(1, text.len() - 1), "%h %h", a, d));
            wr_addr_q.push_back(a);
            wr_data_q.push_back(d);
         end else if (text.len() > 1 && text[0] == "P") begin
            void'($sscanf(text.substr(1, text.len() - 1), "%d %d %h", col, ln, p));
            if (col < 0 || col >= H_TOTAL || ln < 0 || ln >= V_TOTAL) begin
               $display("probe record at column %0d line %0d lies outside the frame", col, ln);
               abort_run();
            end
            probe_map[ln * H_TOTAL + col] = p;
         end
      end
      $fclose(fd);
      if (wr_addr_q.size() == 0 || probe_map.num() == 0) begin
         $display("test data file holds no write or probe records");
         abort_run();
      end
   endtask

   // one word per cycle while a credit is in hand
   task automatic send_writes();
      int idx;
      idx = 0;
      while (idx < wr_addr_q.size()) begin
         @(posedge clk);
         #2;
         if (credits > 0) begin
            wr_valid = 1'b1;
            wr_addr  = wr_addr_q[idx];
            wr_data  = wr_data_q[idx];
            credits--;
            words_sent++;
            idx++;
         end else begin
            wr_valid = 1'b0;
         end
      end
      @(posedge clk);
      #2;
      wr_valid = 1'b0;
   endtask

   task automatic check_ram_contents();
      for (int i = 0; i < wr_addr_q.size(); i++) begin
         check_pixel($sformatf("ram word %h even half", wr_addr_q[i]),
                     wr_data_q[i][35:18], mem[wr_addr_q[i]][35:18]);
         check_pixel($sformatf("ram word %h odd half", wr_addr_q[i]),
                     wr_data_q[i][17:0], mem[wr_addr_q[i]][17:0]);
      end
   endtask

   // ---------------------------------------------------------------------
   // one frame from its first active cycle sampled on the falling edge
   // ---------------------------------------------------------------------
   task automatic scan_frame();
      int     last_fall;
      int     hsync_low;
      int     blank_run;
      int     hsync_falls;
      int     vsync_lines;
      int     active_lines;
      logic   prev_hsync;
      logic   prev_blank_b;
      pixel_t act;
      last_fall    = -1;
      hsync_low    = 0;
      blank_run    = 0;
      hsync_falls  = 0;
      vsync_lines  = 0;
      active_lines = 0;
      prev_hsync   = 1'b1;
      prev_blank_b = 1'b0;
      for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
         if (probe_map.exists(cyc)) begin
            act = {vga_red[7:2], vga_green[7:2], vga_blue[7:2]};
            check_pixel($sformatf("pixel line %0d col %0d", cyc / H_TOTAL, cyc % H_TOTAL),
                        probe_map[cyc], act);
            check_bit("channel pad bits", 1'b0, |{vga_red[1:0], vga_green[1:0], vga_blue[1:0]});
         end
         // line start taken at the hsync falling edge
         if (prev_hsync && !vga_hsync) begin
            if (last_fall >= 0) begin
               check_count("line length", hcount_t'(H_TOTAL), hcount_t'(cyc - last_fall));
            end
            last_fall = cyc;
            hsync_falls++;
            if (!vga_vsync) begin
               vsync_lines++;
            end
         end
         if (!vga_hsync) begin
            hsync_low++;
         end
         if (!prev_hsync && vga_hsync) begin
            check_count("hsync width", hcount_t'(H_SYNC_END - H_SYNC_START), hcount_t'(hsync_low));
            hsync_low = 0;
         end
         if (vga_blank_b) begin
            blank_run++;
         end
         if (prev_blank_b && !vga_blank_b) begin
            check_count("active width", hcount_t'(H_ACTIVE), hcount_t'(blank_run));
            blank_run = 0;
            active_lines++;
         end
         prev_hsync   = vga_hsync;
         prev_blank_b = vga_blank_b;
         @(negedge clk);
      end
      // next frame opens right away with an active cycle
      check_bit("frame length", 1'b1, vga_blank_b);
      check_count("lines per frame", hcount_t'(V_TOTAL), hcount_t'(hsync_falls));
      check_count("vsync lines", hcount_t'(V_SYNC_END - V_SYNC_START), hcount_t'(vsync_lines));
      check_count("active lines", hcount_t'(V_ACTIVE), hcount_t'(active_lines));
   endtask

   initial begin
      reset         = 1'b1;
      wr_valid      = 1'b0;
      wr_addr       = '0;
      wr_data       = '0;
      credits       = WR_CREDITS;
      words_sent    = 0;
      for (int i = 0; i < (1 << 19); i++) begin
         mem[i] = '0;
      end
      load_testdata();
      // three edges under reset
      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         check_reset_outputs("during reset");
      end
      @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      check_reset_outputs("after reset");
      send_writes();
      while (credits != WR_CREDITS) begin
         @(negedge clk);
      end
      // each returned credit stands for exactly one committed word
      check_count("ram writes", hcount_t'(words_sent), hcount_t'(ram_writes));
      check_ram_contents();
      // first vsync pulse ends frame one and line 0 of frame two follows
      while (vga_vsync !== 1'b0) begin
         @(negedge clk);
      end
      while (vga_vsync !== 1'b1) begin
         @(negedge clk);
      end
      while (vga_blank_b !== 1'b1) begin
         @(negedge clk);
      end
      scan_frame();
      $display("No errors");
      $finish;
   end

endmodule

// File: verification/vga_frame_testdata.txt
# W <word address hex> <36-bit word hex, even pixel in the upper 18 bits>
# P <column dec> <line dec> <expected 18-bit pixel hex, red green blue>
W 00000 FC0000FC0
W 00001 000FFFFFF
W 00002 48D16A5A5
W 00003 000060000
W 00004 55554AAAA
W 00005 FFF00003F
W 00200 92491B6DB
W 259FF 3C3C30303
W 5FFFE 444462222
W 5FFFF CCCCC4444
P 0 0 3F000
P 1 0 00FC0
P 2 0 0003F
P 3 0 3FFFF
P 4 0 12345
P 5 0 2A5A5
P 6 0 00001
P 7 0 20000
P 8 0 15555
P 9 0 0AAAA
P 10 0 3FFC0
P 11 0 0003F
P 12 0 00000
P 0 1 24924
P 1022 300 0F0F0
P 1023 300 30303
P 1022 767 33333
P 1023 767 04444
P 600 500 00000

// File: vga_frame.f
hw/vga_frame_pkg.sv
hw/vga_frame_ifs.sv
hw/video_timing_gen.sv
hw/frame_write_queue.sv
hw/vram_arbiter.sv
hw/pixel_unpack.sv
hw/vga_frame_top.sv
verification/vga_frame_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = vga_frame_tb
FILELIST  = vga_frame.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
